// ==== logic/axis_beat_pkg.sv ====
package axis_beat_pkg;

  // --------------------
  // Stream geometry
  // --------------------

  // Default TDATA width of the outgoing stream
  localparam int TDATA_W = 32;

  // Peer sources sharing the one stream
  localparam int NUM_SRC = 2;

  // --------------------
  // Beat
  // --------------------

  // One stream beat, generator to arbiter and arbiter to top
  typedef struct packed {
    logic [TDATA_W-1:0] data;
    logic               last;
  } axis_beat_t;

endpackage

// ==== logic/burst_gen.sv ====
`timescale 1ns/10ps

module burst_gen
  import axis_beat_pkg::*;
  import burst_gen_pkg::*;
#(
  parameter int DATA_W      = TDATA_W,
  parameter int BURST_LEN   = 8,
  parameter int START_COUNT = 4,
  parameter int SRC_ID      = 0
) (
  input  logic       M_AXIS_ACLK,
  input  logic       M_AXIS_ARESETN,
  output axis_beat_t beat,
  output logic       valid,
  input  logic       ready
);

  localparam logic [WAIT_CNT_W-1:0]   WAIT_LAST = WAIT_CNT_W'(START_COUNT - 1);
  localparam logic [BEAT_FIELD_W-1:0] BEAT_LAST = BEAT_FIELD_W'(BURST_LEN - 1);
  localparam logic [SRC_FIELD_W-1:0]  SRC_NUM   = SRC_FIELD_W'(SRC_ID);

  gen_state_e              state_q;
  logic [WAIT_CNT_W-1:0]   wait_cnt_q;
  logic [BEAT_FIELD_W-1:0] beat_idx_q;
  logic [BEAT_FIELD_W-1:0] beat_idx_nxt;
  logic [PKT_FIELD_W-1:0]  pkt_cnt_q;
  logic                    valid_q;
  logic                    last_q;
  logic [DATA_W-1:0]       data_q;
  logic                    xfer;
  logic                    burst_end;

  // Elaboration checks
  if (DATA_W != TDATA_W) begin : g_bad_data_w
    $error("burst_gen: DATA_W must equal the stream TDATA_W");
  end
  if (DATA_W < PAYLOAD_W) begin : g_narrow_data_w
    $error("burst_gen: DATA_W too narrow for the payload fields");
  end
  if (START_COUNT < 1 || BURST_LEN < 1) begin : g_bad_counts
    $error("burst_gen: START_COUNT and BURST_LEN must be at least 1");
  end

  assign xfer         = valid_q && ready;
  assign burst_end    = xfer && (beat_idx_q == BEAT_LAST);
  assign beat_idx_nxt = beat_idx_q + 1'b1;

  // --------------------
  // Control FSM
  // --------------------
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state_q    <= idle;
      wait_cnt_q <= '0;
    end else begin
      unique case (state_q)
        idle: begin
          state_q    <= start_wait;
          wait_cnt_q <= '0;
        end
        start_wait: begin
          if (wait_cnt_q == WAIT_LAST) begin
            state_q <= send_burst;
          end else begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
          end
        end
        send_burst: begin
          if (burst_end) begin
            state_q <= idle;
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

  // --------------------
  // Beat sequencing
  // --------------------
  // First cycle of send_burst raises valid one cycle after entry
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      valid_q    <= 1'b0;
      last_q     <= 1'b0;
      beat_idx_q <= '0;
      pkt_cnt_q  <= '0;
    end else if (state_q == send_burst) begin
      if (!valid_q) begin
        valid_q <= 1'b1;
        last_q  <= (beat_idx_q == BEAT_LAST);
      end else if (burst_end) begin
        valid_q    <= 1'b0;
        last_q     <= 1'b0;
        beat_idx_q <= '0;
        // Wraps at 256
        pkt_cnt_q  <= pkt_cnt_q + 1'b1;
      end else if (xfer) begin
        beat_idx_q <= beat_idx_nxt;
        last_q     <= (beat_idx_nxt == BEAT_LAST);
      end
    end
  end

  // Data word, held under back-pressure
  always_ff @(posedge M_AXIS_ACLK) begin
    if (state_q == send_burst) begin
      if (!valid_q) begin
        data_q <= DATA_W'(make_payload(SRC_NUM, pkt_cnt_q, beat_idx_q));
      end else if (xfer && !burst_end) begin
        data_q <= DATA_W'(make_payload(SRC_NUM, pkt_cnt_q, beat_idx_nxt));
      end
    end
  end

  assign beat  = '{data: data_q, last: last_q};
  assign valid = valid_q;

endmodule

// ==== logic/burst_gen_pkg.sv ====
package burst_gen_pkg;

  // Generator FSM
  typedef enum logic [1:0] {
    idle       = 2'b00,
    start_wait = 2'b01,
    send_burst = 2'b10
  } gen_state_e;

  // --------------------
  // Payload layout, MSB first
  // --------------------
  localparam int SRC_FIELD_W  = 8;
  localparam int PKT_FIELD_W  = 8;
  localparam int BEAT_FIELD_W = 16;
  localparam int PAYLOAD_W    = SRC_FIELD_W + PKT_FIELD_W + BEAT_FIELD_W;

  // Start delay counter, bounds START_COUNT
  localparam int WAIT_CNT_W = 16;

  // Source, packet count, beat index
  function automatic logic [PAYLOAD_W-1:0] make_payload(
    input logic [SRC_FIELD_W-1:0]  src,
    input logic [PKT_FIELD_W-1:0]  pkt,
    input logic [BEAT_FIELD_W-1:0] beat
  );
    return {src, pkt, beat};
  endfunction

endpackage

// ==== logic/packet_arbiter.sv ====
`timescale 1ns/10ps

module packet_arbiter
  import axis_beat_pkg::*;
#(
  parameter int NUM_SRC = axis_beat_pkg::NUM_SRC
) (
  input  logic               M_AXIS_ACLK,
  input  logic               M_AXIS_ARESETN,
  input  axis_beat_t         src_beat [NUM_SRC],
  input  logic [NUM_SRC-1:0] src_valid,
  output logic [NUM_SRC-1:0] src_ready,
  output axis_beat_t         out_beat,
  output logic               out_valid,
  input  logic               out_ready
);

  localparam int IDX_W = (NUM_SRC > 1) ? $clog2(NUM_SRC) : 1;

  logic [IDX_W-1:0] grant_q;
  logic             locked_q;
  logic [IDX_W-1:0] served_q;
  logic [IDX_W-1:0] sel;
  logic [IDX_W:0]   pick;
  logic [IDX_W:0]   rot;
  logic             last_xfer;

  // {found, index} of the first requester after base, up to span steps
  function automatic logic [IDX_W:0] next_req(
    input logic [IDX_W-1:0]   base,
    input logic [NUM_SRC-1:0] req,
    input int                 span
  );
    logic [IDX_W:0] res;
    int             cand;
    res = '0;
    // Walk backwards so the nearest one wins
    for (int k = span; k >= 1; k--) begin
      cand = (int'(base) + k) % NUM_SRC;
      if (req[cand]) begin
        res = {1'b1, IDX_W'(cand)};
      end
    end
    return res;
  endfunction

  // --------------------
  // Selection
  // --------------------
  // Released: the source after the last served one has priority
  assign pick = next_req(served_q, src_valid, NUM_SRC);
  assign sel  = locked_q ? grant_q : pick[IDX_W-1:0];

  // Hand-over target, never the source just finishing
  assign rot = next_req(sel, src_valid, NUM_SRC - 1);

  assign out_beat  = src_beat[sel];
  assign out_valid = src_valid[sel];
  assign last_xfer = out_valid && out_ready && out_beat.last;

  always_comb begin
    src_ready      = '0;
    src_ready[sel] = out_ready;
  end

  // --------------------
  // Grant state
  // --------------------
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      grant_q  <= '0;
      locked_q <= 1'b0;
      // Nobody served yet, so source 0 comes first
      served_q <= IDX_W'(NUM_SRC - 1);
    end else if (last_xfer) begin
      served_q <= sel;
      locked_q <= rot[IDX_W];
      if (rot[IDX_W]) begin
        grant_q <= rot[IDX_W-1:0];
      end
    end else if (!locked_q && pick[IDX_W]) begin
      locked_q <= 1'b1;
      grant_q  <= pick[IDX_W-1:0];
    end
  end

endmodule

// ==== logic/stream_src_top.sv ====
`timescale 1ns/10ps

module stream_src_top
  import axis_beat_pkg::*;
#(
  parameter int DATA_W        = TDATA_W,
  parameter int BURST_LEN     = 8,
  parameter int START_COUNT_0 = 4,
  parameter int START_COUNT_1 = 6
) (
  input  logic                M_AXIS_ACLK,
  input  logic                M_AXIS_ARESETN,
  output logic                M_AXIS_TVALID,
  output logic [DATA_W-1:0]   M_AXIS_TDATA,
  output logic [DATA_W/8-1:0] M_AXIS_TSTRB,
  output logic                M_AXIS_TLAST,
  input  logic                M_AXIS_TREADY
);

  axis_beat_t         gen_beat [NUM_SRC];
  logic [NUM_SRC-1:0] gen_valid;
  logic [NUM_SRC-1:0] gen_ready;
  axis_beat_t         arb_beat;
  logic               arb_valid;

  // --------------------
  // Sources
  // --------------------
  burst_gen #(
    .DATA_W      (DATA_W),
    .BURST_LEN   (BURST_LEN),
    .START_COUNT (START_COUNT_0),
    .SRC_ID      (0)
  ) i_gen_0 (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .beat           (gen_beat[0]),
    .valid          (gen_valid[0]),
    .ready          (gen_ready[0])
  );

  burst_gen #(
    .DATA_W      (DATA_W),
    .BURST_LEN   (BURST_LEN),
    .START_COUNT (START_COUNT_1),
    .SRC_ID      (1)
  ) i_gen_1 (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .beat           (gen_beat[1]),
    .valid          (gen_valid[1]),
    .ready          (gen_ready[1])
  );

  // Packet-locked merge onto M_AXIS
  packet_arbiter #(
    .NUM_SRC (NUM_SRC)
  ) i_arb (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .src_beat       (gen_beat),
    .src_valid      (gen_valid),
    .src_ready      (gen_ready),
    .out_beat       (arb_beat),
    .out_valid      (arb_valid),
    .out_ready      (M_AXIS_TREADY)
  );

  assign M_AXIS_TVALID = arb_valid;
  assign M_AXIS_TDATA  = arb_beat.data;
  assign M_AXIS_TLAST  = arb_beat.last;
  // Every byte lane is a data byte
  assign M_AXIS_TSTRB  = '1;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the stream source testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=stream_src_tb
LOG=sim.log

verilator --binary --timing --assert \
  --top-module "$TOP" \
  -Mdir obj_dir \
  -f stream_src.f

# Keep running past assertion errors so the testbench reports them
./obj_dir/V"$TOP" +verilator+error+limit+1000 | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

echo "Simulation passed"

// ==== sim/stream_src_assert.sv ====
`timescale 1ns/10ps

module stream_src_assert
  import axis_beat_pkg::*;
#(
  parameter int NUM_SRC = axis_beat_pkg::NUM_SRC,
  parameter int IDX_W   = (NUM_SRC > 1) ? $clog2(NUM_SRC) : 1
) (
  input logic               M_AXIS_ACLK,
  input logic               M_AXIS_ARESETN,
  input logic [NUM_SRC-1:0] src_ready,
  input axis_beat_t         out_beat,
  input logic               out_valid,
  input logic               out_ready,
  input logic [IDX_W-1:0]   sel,
  input logic               last_xfer
);

  int hold_fails   = 0;
  int onehot_fails = 0;
  int lock_fails   = 0;
  int fail_count;

  assign fail_count = hold_fails + onehot_fails + lock_fails;

  // Stalled beat stays put
  a_hold: assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
    else begin
      $error("arbiter output changed while stalled");
      hold_fails++;
    end

  a_onehot: assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    $onehot0(src_ready))
    else begin
      $error("more than one source sees ready");
      onehot_fails++;
    end

  // Grant moves only after a last beat
  a_lock: assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    (out_valid && !last_xfer) |=> $stable(sel))
    else begin
      $error("grant changed inside a packet");
      lock_fails++;
    end

endmodule

bind packet_arbiter stream_src_assert #(
  .NUM_SRC (NUM_SRC)
) i_arb_assert (
  .M_AXIS_ACLK    (M_AXIS_ACLK),
  .M_AXIS_ARESETN (M_AXIS_ARESETN),
  .src_ready      (src_ready),
  .out_beat       (out_beat),
  .out_valid      (out_valid),
  .out_ready      (out_ready),
  .sel            (sel),
  .last_xfer      (last_xfer)
);

// ==== sim/stream_src_checker.sv ====
`timescale 1ns/10ps

module stream_src_checker
  import axis_beat_pkg::*;
  import burst_gen_pkg::*;
#(
  parameter int DATA_W    = TDATA_W,
  parameter int BURST_LEN = 8
) (
  input  logic                M_AXIS_ACLK,
  input  logic                M_AXIS_ARESETN,
  input  logic                M_AXIS_TVALID,
  input  logic [DATA_W-1:0]   M_AXIS_TDATA,
  input  logic [DATA_W/8-1:0] M_AXIS_TSTRB,
  input  logic                M_AXIS_TLAST,
  input  logic                M_AXIS_TREADY,
  output int                  error_count,
  output int                  pkt_count
);

  int                      errors     = 0;
  int                      pkts       = 0;
  int                      exp_src    = 0;
  logic [PKT_FIELD_W-1:0]  exp_pkt [NUM_SRC] = '{default: '0};
  logic [BEAT_FIELD_W-1:0] exp_beat   = '0;
  logic                    in_reset_q = 1'b0;

  assign error_count = errors;
  assign pkt_count   = pkts;

  // Prediction for one accepted beat, then step to the next
  task automatic check_beat();
    logic [DATA_W-1:0] exp_data;
    logic              exp_last;
    exp_data = DATA_W'({SRC_FIELD_W'(exp_src), exp_pkt[exp_src], exp_beat});
    exp_last = (exp_beat == BEAT_FIELD_W'(BURST_LEN - 1));
    if (M_AXIS_TDATA !== exp_data || M_AXIS_TLAST !== exp_last) begin
      errors++;
      $display("ERROR %0t: got src %0d pkt %0d idx %0d last %0b",
               $time, M_AXIS_TDATA[BEAT_FIELD_W+PKT_FIELD_W +: SRC_FIELD_W],
               M_AXIS_TDATA[BEAT_FIELD_W +: PKT_FIELD_W],
               M_AXIS_TDATA[0 +: BEAT_FIELD_W], M_AXIS_TLAST);
      $display("ERROR %0t: expected src %0d pkt %0d idx %0d last %0b",
               $time, exp_src, exp_pkt[exp_src], exp_beat, exp_last);
    end
    if (exp_last) begin
      exp_pkt[exp_src] = exp_pkt[exp_src] + 1'b1;
      exp_src          = (exp_src + 1) % NUM_SRC;
      exp_beat         = '0;
      pkts++;
    end else begin
      exp_beat = exp_beat + 1'b1;
    end
  endtask

  // --------------------
  // Port monitor
  // --------------------
  always @(posedge M_AXIS_ACLK) begin
    if (in_reset_q && (M_AXIS_TVALID !== 1'b0 || M_AXIS_TLAST !== 1'b0)) begin
      errors++;
      $display("ERROR %0t: TVALID or TLAST not low under reset", $time);
    end
    if (M_AXIS_TSTRB !== '1) begin
      errors++;
      $display("ERROR %0t: TSTRB is %0h, expected all ones", $time, M_AXIS_TSTRB);
    end
    if (M_AXIS_ARESETN && M_AXIS_TVALID && M_AXIS_TREADY) begin
      check_beat();
    end
    in_reset_q <= !M_AXIS_ARESETN;
  end

endmodule

// ==== sim/stream_src_tb.sv ====
`timescale 1ns/10ps

module stream_src_tb
  import axis_beat_pkg::*;
();

  localparam int          CLK_PERIOD    = 40;
  localparam int          RESET_CYCLES  = 4;
  localparam int          BURST_LEN     = 8;
  localparam int          N_ROWS        = 6;
  // Stall row is ready 1 cycle in 4, doubled for gaps between packets
  localparam int          STALL_FACTOR  = 8;
  localparam int          MARGIN_CYCLES = 500;
  localparam logic [31:0] LCG_MUL       = 32'd1103515245;
  localparam logic [31:0] LCG_INC       = 32'd12345;
  localparam logic [31:0] LCG_SEED      = 32'd62024;

  typedef enum logic [1:0] {
    bp_always,
    bp_alternate,
    bp_random,
    bp_stall
  } bp_mode_e;

  typedef struct packed {
    bp_mode_e    mode;
    logic [7:0]  thresh;
    logic [15:0] pkts;
  } bp_row_t;

  // Last row runs past 256 packets per source so the count wraps
  localparam bp_row_t ROWS [N_ROWS] = '{
    '{mode: bp_always,    thresh: 8'd0,   pkts: 16'd4},
    '{mode: bp_alternate, thresh: 8'd0,   pkts: 16'd4},
    '{mode: bp_random,    thresh: 8'd128, pkts: 16'd6},
    '{mode: bp_stall,     thresh: 8'd0,   pkts: 16'd4},
    '{mode: bp_random,    thresh: 8'd192, pkts: 16'd6},
    '{mode: bp_always,    thresh: 8'd0,   pkts: 16'd520}
  };

  logic                 M_AXIS_ACLK;
  logic                 M_AXIS_ARESETN;
  logic                 M_AXIS_TVALID;
  logic [TDATA_W-1:0]   M_AXIS_TDATA;
  logic [TDATA_W/8-1:0] M_AXIS_TSTRB;
  logic                 M_AXIS_TLAST;
  logic                 M_AXIS_TREADY;
  int                   chk_errors;
  int                   pkts_seen;
  int                   pkts_acked;
  int                   tb_errors;
  int                   asrt_errors;
  int                   cyc;
  int                   target;
  logic [31:0]          lcg_state;

  stream_src_top #(
    .DATA_W        (TDATA_W),
    .BURST_LEN     (BURST_LEN),
    .START_COUNT_0 (4),
    .START_COUNT_1 (6)
  ) i_dut (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .M_AXIS_TVALID  (M_AXIS_TVALID),
    .M_AXIS_TDATA   (M_AXIS_TDATA),
    .M_AXIS_TSTRB   (M_AXIS_TSTRB),
    .M_AXIS_TLAST   (M_AXIS_TLAST),
    .M_AXIS_TREADY  (M_AXIS_TREADY)
  );

  stream_src_checker #(
    .DATA_W    (TDATA_W),
    .BURST_LEN (BURST_LEN)
  ) i_chk (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .M_AXIS_TVALID  (M_AXIS_TVALID),
    .M_AXIS_TDATA   (M_AXIS_TDATA),
    .M_AXIS_TSTRB   (M_AXIS_TSTRB),
    .M_AXIS_TLAST   (M_AXIS_TLAST),
    .M_AXIS_TREADY  (M_AXIS_TREADY),
    .error_count    (chk_errors),
    .pkt_count      (pkts_seen)
  );

  assign asrt_errors = i_dut.i_arb.i_arb_assert.fail_count;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * LCG_MUL + LCG_INC;
  endfunction

  task automatic drive_ready(input bp_row_t row);
    logic rdy;
    case (row.mode)
      bp_always:    rdy = 1'b1;
      bp_alternate: rdy = cyc[0];
      bp_random: begin
        lcg_state = lcg_next(lcg_state);
        rdy       = (lcg_state[23:16] < row.thresh);
      end
      // Long stalls, 12 cycles low then 4 high
      default:      rdy = ((cyc % 16) >= 12);
    endcase
    M_AXIS_TREADY = rdy;
  endtask

  initial begin
    M_AXIS_ACLK = 1'b0;
    forever #(CLK_PERIOD / 2) M_AXIS_ACLK = ~M_AXIS_ACLK;
  end

  // --------------------
  // Watchdog
  // --------------------
  initial begin : watchdog
    int total_beats;
    int limit_ns;
    total_beats = 0;
    for (int r = 0; r < N_ROWS; r++) begin
      total_beats += int'(ROWS[r].pkts) * BURST_LEN;
    end
    limit_ns = (total_beats * STALL_FACTOR + MARGIN_CYCLES) * CLK_PERIOD;
    #(limit_ns);
    $display("Timeout: the stream stopped before all table rows were accepted");
    $display("Test failed");
    $finish;
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin : stimulus
    M_AXIS_ARESETN = 1'b0;
    M_AXIS_TREADY  = 1'b0;
    tb_errors      = 0;
    pkts_acked     = 0;
    cyc            = 0;
    target         = 0;
    lcg_state      = LCG_SEED;
    repeat (RESET_CYCLES) @(posedge M_AXIS_ACLK);
    #1;
    M_AXIS_ARESETN = 1'b1;

    for (int r = 0; r < N_ROWS; r++) begin
      target += int'(ROWS[r].pkts);
      while (pkts_acked < target) begin
        drive_ready(ROWS[r]);
        // Last beat offered and accepted on the coming edge
        if (M_AXIS_TVALID && M_AXIS_TREADY && M_AXIS_TLAST) begin
          pkts_acked++;
        end
        @(posedge M_AXIS_ACLK);
        #1;
        cyc++;
      end
    end

    // Checker packet count against the table total
    M_AXIS_TREADY = 1'b0;
    repeat (4) @(posedge M_AXIS_ACLK);
    if (pkts_seen != target) begin
      tb_errors++;
      $display("ERROR %0t: checker counted %0d packets, table total is %0d",
               $time, pkts_seen, target);
    end

    $display("Error counts: checker %0d, assertions %0d, testbench %0d",
             chk_errors, asrt_errors, tb_errors);
    if (chk_errors == 0 && asrt_errors == 0 && tb_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== stream_src.f ====
logic/axis_beat_pkg.sv
logic/burst_gen_pkg.sv
logic/burst_gen.sv
logic/packet_arbiter.sv
logic/stream_src_top.sv
sim/stream_src_checker.sv
sim/stream_src_assert.sv
sim/stream_src_tb.sv
